// ==== src/game_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// geometry and timing of the mining game view
// sprite kind value doubles as pixel colour
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package game_pkg;

	// screen
	localparam int screen_w = 32;
	localparam int screen_h = 24;
	localparam int coord_x_w = 6;
	localparam int coord_y_w = 5;

	localparam int max_objects = 8; // per kind
	localparam int count_w = 4;

	// sprite sizes in pixels
	localparam int gold_w = 4;
	localparam int gold_h = 4;
	localparam int stone_w = 3;
	localparam int stone_h = 3;
	localparam int diamond_w = 2;
	localparam int diamond_h = 2;
	localparam int hook_w = 2;
	localparam int hook_h = 4;
	localparam int hook_x = 15;
	localparam int hook_y = 0;
	localparam int num_w = 8; // score box, no digits
	localparam int num_h = 4;
	localparam int num_x = 0;
	localparam int num_y = 0;

	// frame timing
	localparam int frame_div = 1536; // longer than a full frame draw
	localparam int game_frames = 3; // game shows game_frames+1 frames

	typedef enum logic [2:0] {
		kind_background,
		kind_gold,
		kind_stone,
		kind_diamond,
		kind_hook,
		kind_num
	} sprite_kind_t;

	typedef enum logic [3:0] {
		place,
		draw_background,
		pick_object,
		draw_object,
		object_done,
		draw_hook,
		draw_num,
		game,
		game_done
	} view_state_t;

endpackage

`default_nettype wire

// ==== src/game_clock.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame pulse every frame_div enabled cycles
// game_end lags the last counted pulse by one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module game_clock
	import game_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic timer_enable,
	input wire logic timer_clear,
	output logic frame,
	output logic game_end
);

	localparam int div_w = $clog2(frame_div);
	localparam int cnt_w = $clog2(game_frames + 1);

	logic [div_w-1:0] div_cnt;
	logic [cnt_w-1:0] frame_cnt;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			div_cnt <= '0;
			frame_cnt <= '0;
			frame <= 1'b0;
			game_end <= 1'b0;
		end else if (timer_clear) begin
			div_cnt <= '0;
			frame_cnt <= '0;
			frame <= 1'b0;
			game_end <= 1'b0;
		end else begin
			frame <= 1'b0;
			game_end <= (frame_cnt == cnt_w'(game_frames));
			if (timer_enable) begin
				if (div_cnt == div_w'(frame_div - 1)) begin
					div_cnt <= '0;
					frame <= 1'b1;
					if (frame_cnt != cnt_w'(game_frames))
						frame_cnt <= frame_cnt + 1'b1; // saturates
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/view_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one frame per pass and waits on draw_done
// max counts above max_objects are clamped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module view_sequencer
	import game_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic go,
	input wire logic draw_done,
	input wire logic frame,
	input wire logic game_end,
	input wire logic [count_w-1:0] gold_count,
	input wire logic [count_w-1:0] stone_count,
	input wire logic [count_w-1:0] diamond_count,
	input wire logic [count_w-1:0] max_gold,
	input wire logic [count_w-1:0] max_stone,
	input wire logic [count_w-1:0] max_diamond,
	output logic draw_start,
	output sprite_kind_t draw_kind,
	output logic place,
	output logic clear_counts,
	output logic timer_enable,
	output logic timer_clear,
	output logic game_over
);

	view_state_t state, next_state;
	sprite_kind_t pick_kind;
	logic entering_draw;

	function automatic logic [count_w-1:0] clamp_max(input logic [count_w-1:0] m);
		return (m > count_w'(max_objects)) ? count_w'(max_objects) : m;
	endfunction

	function automatic logic is_draw(input view_state_t s);
		return (s == draw_background) || (s == draw_object) ||
			(s == draw_hook) || (s == draw_num);
	endfunction

	// gold first, then stone, then diamond
	always_comb begin
		pick_kind = kind_gold;
		if (gold_count >= clamp_max(max_gold)) begin
			pick_kind = (stone_count < clamp_max(max_stone)) ? kind_stone : kind_diamond;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			game_pkg::place: next_state = draw_background;
			draw_background: if (draw_done) next_state = pick_object;
			pick_object: begin
				if (gold_count < clamp_max(max_gold) ||
						stone_count < clamp_max(max_stone) ||
						diamond_count < clamp_max(max_diamond))
					next_state = draw_object;
				else
					next_state = draw_hook;
			end
			draw_object: if (draw_done) next_state = object_done;
			object_done: next_state = pick_object; // counts settle here
			draw_hook: if (draw_done) next_state = draw_num;
			draw_num: if (draw_done) next_state = game;
			game: begin
				if (game_end)
					next_state = game_done;
				else if (frame)
					next_state = draw_background;
			end
			game_done: if (go) next_state = game_pkg::place;
			default: next_state = game_pkg::place;
		endcase
	end

	assign entering_draw = is_draw(next_state) && (next_state != state);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= game_pkg::place;
			draw_start <= 1'b0;
			draw_kind <= kind_background;
			place <= 1'b0;
		end else begin
			state <= next_state;
			draw_start <= entering_draw; // one cycle on entry
			place <= (state == game_pkg::place); // seed strobe follows the place state
			if (entering_draw) begin
				case (next_state)
					draw_object: draw_kind <= pick_kind;
					draw_hook: draw_kind <= kind_hook;
					draw_num: draw_kind <= kind_num;
					default: draw_kind <= kind_background;
				endcase
			end
		end
	end

	assign timer_clear = (state == game_pkg::place);
	assign clear_counts = (state == game);
	assign timer_enable = is_draw(state) || (state == game);
	assign game_over = (state == game_done);

endmodule

`default_nettype wire

// ==== src/object_placer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// origins depend only on seed, kind and index
// so one game redraws the same picture
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module object_placer
	import game_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic place,
	input wire logic draw_start,
	input wire sprite_kind_t draw_kind,
	input wire logic clear_counts,
	output logic [count_w-1:0] gold_count,
	output logic [count_w-1:0] stone_count,
	output logic [count_w-1:0] diamond_count,
	output logic raster_start,
	output sprite_kind_t raster_kind,
	output logic [coord_x_w-1:0] origin_x,
	output logic [coord_y_w-1:0] origin_y
);

	logic [15:0] lfsr;
	logic [15:0] seed;
	logic [coord_x_w-1:0] next_x;
	logic [coord_y_w-1:0] next_y;

	// number of legal origins along each axis
	function automatic logic [5:0] span_x(input sprite_kind_t k);
		case (k)
			kind_gold: return 6'(screen_w - gold_w + 1);
			kind_stone: return 6'(screen_w - stone_w + 1);
			kind_diamond: return 6'(screen_w - diamond_w + 1);
			default: return 6'd1;
		endcase
	endfunction

	function automatic logic [5:0] span_y(input sprite_kind_t k);
		case (k)
			kind_gold: return 6'(screen_h - gold_h + 1);
			kind_stone: return 6'(screen_h - stone_h + 1);
			kind_diamond: return 6'(screen_h - diamond_h + 1);
			default: return 6'd1;
		endcase
	endfunction

	function automatic logic [5:0] scale(input logic [7:0] v, input logic [5:0] span);
		logic [13:0] p;
		p = v * span;
		return p[13:8]; // always below span
	endfunction

	always_comb begin
		logic [count_w-1:0] idx;
		logic [15:0] h;
		logic [5:0] sx;
		logic [5:0] sy;
		case (draw_kind)
			kind_stone: idx = stone_count;
			kind_diamond: idx = diamond_count;
			default: idx = gold_count;
		endcase
		h = seed ^ {draw_kind, idx, draw_kind, idx, 2'b01};
		h = h * 16'h9e37;
		sx = scale(h[15:8], span_x(draw_kind));
		sy = scale(h[11:4], span_y(draw_kind));
		case (draw_kind)
			kind_hook: begin
				next_x = coord_x_w'(hook_x);
				next_y = coord_y_w'(hook_y);
			end
			kind_num: begin
				next_x = coord_x_w'(num_x);
				next_y = coord_y_w'(num_y);
			end
			kind_gold, kind_stone, kind_diamond: begin
				next_x = sx[coord_x_w-1:0];
				next_y = sy[coord_y_w-1:0];
			end
			default: begin // background covers the screen
				next_x = '0;
				next_y = '0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lfsr <= 16'hace1;
			gold_count <= '0;
			stone_count <= '0;
			diamond_count <= '0;
			raster_start <= 1'b0;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			raster_start <= draw_start;
			if (clear_counts) begin
				gold_count <= '0;
				stone_count <= '0;
				diamond_count <= '0;
			end else if (draw_start) begin
				case (draw_kind)
					kind_gold: gold_count <= gold_count + 1'b1;
					kind_stone: stone_count <= stone_count + 1'b1;
					kind_diamond: diamond_count <= diamond_count + 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (place)
			seed <= lfsr; // held for the whole game
		if (draw_start) begin
			raster_kind <= draw_kind;
			origin_x <= next_x;
			origin_y <= next_y;
		end
	end

endmodule

`default_nettype wire

// ==== src/sprite_rasterizer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one pixel per cycle, row order, no stall
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sprite_rasterizer
	import game_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic raster_start,
	input wire sprite_kind_t raster_kind,
	input wire logic [coord_x_w-1:0] origin_x,
	input wire logic [coord_y_w-1:0] origin_y,
	output logic [coord_x_w-1:0] pix_x,
	output logic [coord_y_w-1:0] pix_y,
	output sprite_kind_t pix_color,
	output logic plot,
	output logic draw_done
);

	logic [coord_x_w-1:0] base_x, col, col_last;
	logic [coord_y_w-1:0] base_y, row, row_last;

	function automatic logic [coord_x_w-1:0] width_last(input sprite_kind_t k);
		case (k)
			kind_gold: return coord_x_w'(gold_w - 1);
			kind_stone: return coord_x_w'(stone_w - 1);
			kind_diamond: return coord_x_w'(diamond_w - 1);
			kind_hook: return coord_x_w'(hook_w - 1);
			kind_num: return coord_x_w'(num_w - 1);
			default: return coord_x_w'(screen_w - 1);
		endcase
	endfunction

	function automatic logic [coord_y_w-1:0] height_last(input sprite_kind_t k);
		case (k)
			kind_gold: return coord_y_w'(gold_h - 1);
			kind_stone: return coord_y_w'(stone_h - 1);
			kind_diamond: return coord_y_w'(diamond_h - 1);
			kind_hook: return coord_y_w'(hook_h - 1);
			kind_num: return coord_y_w'(num_h - 1);
			default: return coord_y_w'(screen_h - 1);
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!resetn) begin
			plot <= 1'b0;
			draw_done <= 1'b0;
			col <= '0;
			row <= '0;
		end else begin
			draw_done <= 1'b0;
			if (raster_start) begin
				plot <= 1'b1;
				col <= '0;
				row <= '0;
			end else if (plot) begin
				if (col == col_last) begin
					col <= '0;
					if (row == row_last) begin
						plot <= 1'b0; // last pixel just shown
						draw_done <= 1'b1;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (raster_start) begin
			base_x <= origin_x;
			base_y <= origin_y;
			col_last <= width_last(raster_kind);
			row_last <= height_last(raster_kind);
			pix_color <= raster_kind;
		end
	end

	assign pix_x = base_x + col;
	assign pix_y = base_y + row;

endmodule

`default_nettype wire

// ==== src/game_view_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel write stream out, no video memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module game_view_top
	import game_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic go,
	input wire logic [count_w-1:0] max_gold,
	input wire logic [count_w-1:0] max_stone,
	input wire logic [count_w-1:0] max_diamond,
	output logic [coord_x_w-1:0] pix_x,
	output logic [coord_y_w-1:0] pix_y,
	output sprite_kind_t pix_color,
	output logic plot,
	output logic game_over
);

	logic frame, game_end;
	logic timer_enable, timer_clear;
	logic draw_start, draw_done;
	sprite_kind_t draw_kind, raster_kind;
	logic place, clear_counts, raster_start;
	logic [count_w-1:0] gold_count, stone_count, diamond_count;
	logic [coord_x_w-1:0] origin_x;
	logic [coord_y_w-1:0] origin_y;

	game_clock clock_i (
		.clk, .resetn, .timer_enable, .timer_clear, .frame, .game_end
	);

	view_sequencer seq_i (
		.clk, .resetn, .go, .draw_done, .frame, .game_end,
		.gold_count, .stone_count, .diamond_count,
		.max_gold, .max_stone, .max_diamond,
		.draw_start, .draw_kind, .place, .clear_counts,
		.timer_enable, .timer_clear, .game_over
	);

	object_placer placer_i (
		.clk, .resetn, .place, .draw_start, .draw_kind, .clear_counts,
		.gold_count, .stone_count, .diamond_count,
		.raster_start, .raster_kind, .origin_x, .origin_y
	);

	sprite_rasterizer raster_i (
		.clk, .resetn, .raster_start, .raster_kind, .origin_x, .origin_y,
		.pix_x, .pix_y, .pix_color, .plot, .draw_done
	);

endmodule

`default_nettype wire

// ==== verif/game_view_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound to game_view_top, needs assertions enabled in the simulator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module game_view_checker
	import game_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic go,
	input wire logic [coord_x_w-1:0] pix_x,
	input wire logic [coord_y_w-1:0] pix_y,
	input wire logic plot,
	input wire logic game_over
);

	plot_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		plot |-> (pix_x < coord_x_w'(screen_w)) && (pix_y < coord_y_w'(screen_h)))
		else $error("pixel off screen at %0d,%0d", pix_x, pix_y);

	no_plot_when_over: assert property (@(posedge clk) disable iff (!resetn)
		!(plot && game_over))
		else $error("plot while game_over is high");

	// sync reset clears outputs one edge later
	quiet_in_reset: assert property (@(posedge clk)
		!resetn |=> (!plot && !game_over))
		else $error("plot or game_over high after a reset cycle");

	over_holds: assert property (@(posedge clk) disable iff (!resetn)
		(game_over && !go) |=> game_over)
		else $error("game_over dropped without go");

endmodule

bind game_view_top game_view_checker checker_i (
	.clk, .resetn, .go, .pix_x, .pix_y, .plot, .game_over
);

`default_nettype wire

// ==== verif/game_view_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reads verif/game_view_golden.txt relative to the project root
// one game per table row with 0 to 8 objects per kind
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module game_view_tb
	import game_pkg::*;
();

	localparam int max_tests = 32;
	localparam int quiet_cycles = 16;

	logic clk;
	logic resetn;
	logic go;
	logic [count_w-1:0] max_gold, max_stone, max_diamond;
	logic [coord_x_w-1:0] pix_x;
	logic [coord_y_w-1:0] pix_y;
	sprite_kind_t pix_color;
	logic plot;
	logic game_over;

	logic [8*16-1:0] test_name [max_tests];
	int gold_tab [max_tests];
	int stone_tab [max_tests];
	int diamond_tab [max_tests];
	int total_tab [max_tests];
	int num_tests;
	int cur;
	int error_count;
	int failed_tests;
	int limit_cycles;
	int cycle_count;

	// indexed by drawing rank
	int kind_plots [6];
	int sum_x [6];
	int sum_y [6];
	int ref_x [6];
	int ref_y [6];
	int frame_plots;
	int top_rank;
	int frames_in_game;
	logic in_num_run;

	game_view_top dut_i (
		.clk, .resetn, .go, .max_gold, .max_stone, .max_diamond,
		.pix_x, .pix_y, .pix_color, .plot, .game_over
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int draw_rank(input sprite_kind_t k);
		case (k)
			kind_background: return 0;
			kind_gold: return 1;
			kind_stone: return 2;
			kind_diamond: return 3;
			kind_hook: return 4;
			default: return 5; // score box
		endcase
	endfunction

	function automatic string rank_name(input int rank);
		case (rank)
			0: return "background";
			1: return "gold";
			2: return "stone";
			3: return "diamond";
			4: return "hook";
			default: return "score box";
		endcase
	endfunction

	function automatic int expected_plots(input int rank, input int t);
		case (rank)
			0: return screen_w * screen_h;
			1: return gold_w * gold_h * gold_tab[t];
			2: return stone_w * stone_h * stone_tab[t];
			3: return diamond_w * diamond_h * diamond_tab[t];
			4: return hook_w * hook_h;
			default: return num_w * num_h;
		endcase
	endfunction

	task automatic read_golden();
		int fd;
		int n;
		logic [8*96-1:0] line;
		fd = $fopen("verif/game_view_golden.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && num_tests < max_tests) begin
				line = '0;
				n = $fgets(line, fd);
				n = $sscanf(line, "%s %d %d %d %d", test_name[num_tests], gold_tab[num_tests],
					stone_tab[num_tests], diamond_tab[num_tests], total_tab[num_tests]);
				if (n == 5)
					num_tests++; // comment and blank lines fall through
			end
			$fclose(fd);
		end
	endtask

	task automatic check_table_row(input int t);
		int rule_total;
		rule_total = 0;
		for (int i = 0; i < 6; i++)
			rule_total += expected_plots(i, t);
		if (rule_total != total_tab[t]) begin
			$display("golden row %0s gives total %0d but the sprite areas add up to %0d",
				test_name[t], total_tab[t], rule_total);
			error_count++;
		end
	endtask

	task automatic clear_frame();
		for (int i = 0; i < 6; i++) begin
			kind_plots[i] = 0;
			sum_x[i] = 0;
			sum_y[i] = 0;
		end
		frame_plots = 0;
		top_rank = 0;
	endtask

	task automatic end_frame();
		for (int i = 0; i < 6; i++) begin
			if (kind_plots[i] != expected_plots(i, cur)) begin
				$display("Mismatch at %0t: %0s frame %0d has %0d %0s plots, expected %0d",
					$time, test_name[cur], frames_in_game, kind_plots[i], rank_name(i),
					expected_plots(i, cur));
				error_count++;
			end
			if (frames_in_game == 0) begin
				ref_x[i] = sum_x[i];
				ref_y[i] = sum_y[i];
			end else if (sum_x[i] != ref_x[i] || sum_y[i] != ref_y[i]) begin
				$display("Mismatch at %0t: %0s frame %0d %0s sums %0d,%0d, first frame %0d,%0d",
					$time, test_name[cur], frames_in_game, rank_name(i), sum_x[i], sum_y[i],
					ref_x[i], ref_y[i]);
				error_count++;
			end
		end
		if (frame_plots != total_tab[cur]) begin
			$display("Mismatch at %0t: %0s frame %0d total %0d, expected %0d", $time,
				test_name[cur], frames_in_game, frame_plots, total_tab[cur]);
			error_count++;
		end
		frames_in_game++;
		clear_frame();
	endtask

	task automatic apply_counts(input int t);
		max_gold = count_w'(gold_tab[t]);
		max_stone = count_w'(stone_tab[t]);
		max_diamond = count_w'(diamond_tab[t]);
	endtask

	// pixel monitor samples on the falling edge
	always @(negedge clk) begin : monitor
		int rank;
		if (!resetn) begin
			if (plot !== 1'b0 || game_over !== 1'b0) begin
				$display("Mismatch at %0t: plot or game_over not low during reset", $time);
				error_count++;
			end
		end else begin
			if (in_num_run && !(plot && pix_color == kind_num))
				end_frame(); // score box run is over
			in_num_run = plot && (pix_color == kind_num);
			if (plot) begin
				rank = draw_rank(pix_color);
				if (int'(pix_x) >= screen_w || int'(pix_y) >= screen_h) begin
					$display("Mismatch at %0t: pixel %0d,%0d off screen", $time, pix_x, pix_y);
					error_count++;
				end
				if (game_over) begin
					$display("Mismatch at %0t: plot while game_over is high", $time);
					error_count++;
				end
				if (rank < top_rank) begin
					$display("Mismatch at %0t: %0s %0s drawn after %0s", $time,
						test_name[cur], rank_name(rank), rank_name(top_rank));
					error_count++;
				end else begin
					top_rank = rank;
				end
				kind_plots[rank]++;
				sum_x[rank] += int'(pix_x);
				sum_y[rank] += int'(pix_y);
				frame_plots++;
			end
		end
	end

	initial begin : watchdog
		cycle_count = 0;
		@(negedge clk);
		while (limit_cycles == 0 || cycle_count < limit_cycles) begin
			@(negedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not end within %0d cycles", limit_cycles);
		$display("Done: errors found");
		$finish;
	end

	initial begin : run
		int test_errors;
		resetn = 1'b0;
		go = 1'b0;
		max_gold = '0;
		max_stone = '0;
		max_diamond = '0;
		error_count = 0;
		failed_tests = 0;
		num_tests = 0;
		limit_cycles = 0;
		frames_in_game = 0;
		in_num_run = 1'b0;
		cur = 0;
		clear_frame();
		read_golden();
		if (num_tests == 0) begin
			$display("no test rows read from verif/game_view_golden.txt");
			$display("Done: errors found");
			$finish;
		end else begin
			limit_cycles = num_tests * (game_frames + 2) * frame_div;
			for (cur = 0; cur < num_tests; cur++) begin
				test_errors = error_count;
				check_table_row(cur);
				if (cur == 0) begin
					apply_counts(cur);
					repeat (4) @(posedge clk);
					#2 resetn = 1'b1; // first game runs without go
				end else begin
					@(posedge clk);
					#2;
					apply_counts(cur);
					frames_in_game = 0;
					go = 1'b1;
					@(posedge clk);
					#2 go = 1'b0;
				end
				do @(negedge clk); while (!game_over);
				@(posedge clk);
				#2;
				if (frames_in_game != game_frames + 1) begin
					$display("Mismatch at %0t: %0s drew %0d frames, expected %0d", $time,
						test_name[cur], frames_in_game, game_frames + 1);
					error_count++;
				end
				if (frame_plots != 0) begin
					$display("%0s left an unfinished frame of %0d plots", test_name[cur],
						frame_plots);
					error_count++;
				end
				repeat (quiet_cycles) begin
					@(negedge clk);
					if (!game_over) begin
						$display("Mismatch at %0t: game_over dropped without go", $time);
						error_count++;
					end
				end
				test_errors = error_count - test_errors;
				if (test_errors != 0)
					failed_tests++;
				$display("test %0d %0s: %0s, %0d frames, %0d errors", cur, test_name[cur],
					(test_errors == 0) ? "ok" : "FAILED", frames_in_game, test_errors);
			end
			$display("summary: %0d tests, %0d failed, %0d errors", num_tests, failed_tests,
				error_count);
			if (error_count == 0) begin
				$display("Done: no errors");
			end else begin
				$display("Done: errors found");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verif/game_view_golden.txt ====
# name max_gold max_stone max_diamond frame_total
# frame_total = 768 + 16*gold + 9*stone + 4*diamond + 8 + 32
empty 0 0 0 808
one_each 1 1 1 837
gold_only 3 0 0 856
stone_only 0 5 0 853
diamond_full 0 0 8 840
mixed 2 4 6 900
all_full 8 8 8 1040
gold_full 8 0 2 944
few 5 2 3 918
stone_full 1 8 0 896
stone_diamond 0 3 7 863
gold_stone 6 6 0 958
odd 7 1 5 949
pair 4 0 4 888

// ==== tb.f ====
src/game_pkg.sv
src/game_clock.sv
src/view_sequencer.sv
src/object_placer.sv
src/sprite_rasterizer.sv
src/game_view_top.sv
verif/game_view_checker.sv
verif/game_view_tb.sv

// ==== Makefile ====
# Verilator build and run of the game view testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module game_view_tb -Mdir obj_dir
	./obj_dir/Vgame_view_tb > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "no result in $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
